// File: test/dcache_testdata.txt
// kind addr mask data expected; 1 load, 2 store, 3 load hit, 4 load with write-back, 0 end
// kind 4 puts the write-back address in the mask column and the write-back word in data
1 40000100 0 00000000 41000100
3 40000100 0 00000000 41000100
2 40000200 f deadbeef 00000000
3 40000200 0 00000000 deadbeef
2 40000300 1 000000a1 00000000
3 40000300 0 00000000 430003a1
2 40000300 2 123456b2 00000000
3 40000300 0 00000000 4300b2a1
2 40000300 4 000000c3 00000000
3 40000300 0 00000000 43c3b2a1
2 40000300 8 ffffffd4 00000000
3 40000300 0 00000000 d4c3b2a1
2 40000300 3 aaaa5566 00000000
3 40000300 0 00000000 d4c35566
2 40000300 c 00007788 00000000
3 40000300 0 00000000 77885566
2 40000300 f 0badf00d 00000000
3 40000300 0 00000000 0badf00d
4 40000b00 40000300 0badf00d 4b000b00
1 40000300 0 00000000 0badf00d
4 40001a00 40000200 deadbeef 5a001a00
1 4007f804 0 00000000 b803f804
2 4007f804 f 5555aaaa 00000000
4 40000004 4007f804 5555aaaa 40040004
0 00000000 0 00000000 00000000

// File: dcache.f
verilog/dcache_geom_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_mem_if.sv
verilog/dcache_req_decode.sv
verilog/dcache_ctrl.sv
verilog/dcache_store.sv
verilog/dcache_load_return.sv
verilog/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: test/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

  localparam logic [7:0]  MEM_BASE          = 8'h40;
  localparam logic [31:0] SEED              = 32'h2182_6791;
  localparam int          MAX_RECORDS       = 64;
  localparam int          FIELDS            = 5;
  localparam int          CYCLES_PER_RECORD = 40;

  logic        clk_i;
  logic        rst_i;
  logic        sel_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [3:0]  wmask_i;
  logic [31:0] wdata_i;
  logic [31:0] rdata_o;
  logic        stall_o;
  logic [31:0] mem_addr_o;
  logic        mem_valid_o;
  logic [31:0] mem_wdata_o;
  logic [3:0]  mem_we_o;
  logic [31:0] mem_rdata_i;
  logic        mem_ready_i;

  int          wr_count;
  int          rd_count;
  logic [31:0] last_wr_addr;
  logic [31:0] last_wr_data;

  // Record columns are kind, address, mask, data and expected
  logic [31:0] tdata [MAX_RECORDS*FIELDS];
  int          n_records;

  dcache_top #(
    .MEM_BASE (MEM_BASE)
  ) uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sel_i       (sel_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wmask_i     (wmask_i),
    .wdata_i     (wdata_i),
    .rdata_o     (rdata_o),
    .stall_o     (stall_o),
    .mem_addr_o  (mem_addr_o),
    .mem_valid_o (mem_valid_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_we_o    (mem_we_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_ready_i (mem_ready_i)
  );

  dcache_mem_model #(
    .SEED (SEED)
  ) mem_model (
    .clk_i          (clk_i),
    .addr_i         (mem_addr_o),
    .valid_i        (mem_valid_o),
    .wdata_i        (mem_wdata_o),
    .we_i           (mem_we_o),
    .rdata_o        (mem_rdata_i),
    .ready_o        (mem_ready_i),
    .wr_count_o     (wr_count),
    .rd_count_o     (rd_count),
    .last_wr_addr_o (last_wr_addr),
    .last_wr_data_o (last_wr_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Budget grows with the number of records
  initial begin
    wait (n_records > 0);
    repeat (n_records * CYCLES_PER_RECORD + 10) @(posedge clk_i);
    $display("Error: cache stalled, requests did not finish within %0d cycles",
             n_records * CYCLES_PER_RECORD + 10);
    $display("tests failed");
    $fatal(1, "watchdog timeout");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // Drives one core request and holds it until stall_o falls
  task automatic run_request(input logic we, input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] data, output int stalls,
                             output logic [31:0] rdata);
    @(posedge clk_i);
    #2;
    sel_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wmask_i = mask;
    wdata_i = data;
    stalls  = 0;
    @(negedge clk_i);
    while (stall_o) begin
      stalls++;
      @(negedge clk_i);
    end
    rdata = rdata_o;
    @(posedge clk_i);
    #2;
    sel_i = 1'b0;
    we_i  = 1'b0;
  endtask

  initial begin
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] mask;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] rdata;
    int          stalls;
    int          xfers_before;
    int          wr_before;
    rst_i     = 1'b1;
    sel_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wmask_i   = '0;
    wdata_i   = '0;
    n_records = 0;
    for (int i = 0; i < MAX_RECORDS * FIELDS; i++) begin
      tdata[i] = '0;
    end
    $readmemh("test/dcache_testdata.txt", tdata);
    while (n_records < MAX_RECORDS && tdata[n_records * FIELDS] != 0) begin
      n_records++;
    end
    if (n_records == 0) begin
      $display("Error: no test records found in the data file");
      $display("tests failed");
      $fatal(1, "empty test data");
    end

    repeat (5) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("reset stall_o", 32'd0, {31'd0, stall_o});
    check_value("reset mem_valid_o", 32'd0, {31'd0, mem_valid_o});
    check_value("reset mem_we_o", 32'd0, {28'd0, mem_we_o});

    for (int rec = 0; rec < n_records; rec++) begin
      kind     = tdata[rec * FIELDS];
      addr     = tdata[rec * FIELDS + 1];
      mask     = tdata[rec * FIELDS + 2];
      data     = tdata[rec * FIELDS + 3];
      expected = tdata[rec * FIELDS + 4];
      case (kind)
        32'd1: begin
          run_request(1'b0, addr, 4'h0, 32'h0, stalls, rdata);
          check_value($sformatf("record %0d load data", rec), expected, rdata);
        end
        32'd2: begin
          run_request(1'b1, addr, mask[3:0], data, stalls, rdata);
        end
        32'd3: begin
          xfers_before = rd_count + wr_count;
          run_request(1'b0, addr, 4'h0, 32'h0, stalls, rdata);
          check_value($sformatf("record %0d hit data", rec), expected, rdata);
          check_value($sformatf("record %0d hit stall cycles", rec), 32'd2, stalls);
          check_value($sformatf("record %0d hit memory transfers", rec),
                      xfers_before, rd_count + wr_count);
        end
        32'd4: begin
          // Mask and data columns hold the expected write-back
          wr_before = wr_count;
          run_request(1'b0, addr, 4'h0, 32'h0, stalls, rdata);
          check_value($sformatf("record %0d write-back count", rec), wr_before + 1, wr_count);
          check_value($sformatf("record %0d write-back address", rec), mask, last_wr_addr);
          check_value($sformatf("record %0d write-back data", rec), data, last_wr_data);
          check_value($sformatf("record %0d load data", rec), expected, rdata);
        end
        default: begin
          $display("Error: record %0d has an unknown kind %0h", rec, kind);
          $display("tests failed");
          $fatal(1, "bad test data");
        end
      endcase
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// File: test/dcache_mem_model.sv
`timescale 1ns/1ns

module dcache_mem_model #(
  parameter logic [31:0] SEED = 32'h2182_6791
) (
  input  logic        clk_i,
  input  logic [31:0] addr_i,
  input  logic        valid_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  we_i,
  output logic [31:0] rdata_o,
  output logic        ready_o,
  output int          wr_count_o,
  output int          rd_count_o,
  output logic [31:0] last_wr_addr_o,
  output logic [31:0] last_wr_data_o
);

  // Write log, also serves as the memory contents
  logic [31:0] log_addr[$];
  logic [31:0] log_data[$];

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] word;
    // Untouched words carry a pattern built from the address
    word = {addr[31:16] ^ addr[15:0], addr[15:0]};
    for (int i = 0; i < log_addr.size(); i++) begin
      if (log_addr[i] == addr) begin
        word = log_data[i];
      end
    end
    return word;
  endfunction

  initial begin : respond
    logic        busy;
    int          wait_left;
    logic [31:0] merged;
    ready_o        = 1'b0;
    rdata_o        = '0;
    wr_count_o     = 0;
    rd_count_o     = 0;
    last_wr_addr_o = '0;
    last_wr_data_o = '0;
    busy           = 1'b0;
    wait_left      = 0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk_i);
      #2;
      ready_o = 1'b0;
      if (valid_i) begin
        // New transfer picks its own latency
        if (!busy) begin
          busy      = 1'b1;
          wait_left = $urandom_range(3, 0);
        end
        if (wait_left == 0) begin
          if (we_i != 4'b0000) begin
            merged = read_word(addr_i);
            for (int b = 0; b < 4; b++) begin
              if (we_i[b]) begin
                merged[b*8 +: 8] = wdata_i[b*8 +: 8];
              end
            end
            log_addr.push_back(addr_i);
            log_data.push_back(merged);
            last_wr_addr_o = addr_i;
            last_wr_data_o = merged;
            wr_count_o++;
          end else begin
            rdata_o = read_word(addr_i);
            rd_count_o++;
          end
          ready_o = 1'b1;
          busy    = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
  parameter logic [7:0] MEM_BASE = dcache_geom_pkg::MEM_BASE_DEFAULT
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    sel_i,
  input  logic                    we_i,
  input  logic [31:0]             addr_i,
  input  dcache_bus_pkg::bmask_t  wmask_i,
  input  logic [31:0]             wdata_i,
  output logic [31:0]             rdata_o,
  output logic                    stall_o,
  output logic [31:0]             mem_addr_o,
  output logic                    mem_valid_o,
  output logic [31:0]             mem_wdata_o,
  output logic [3:0]              mem_we_o,
  input  logic [31:0]             mem_rdata_i,
  input  logic                    mem_ready_i
);
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  req_kind_e   kind;
  index_t      index;
  tag_t        tag;
  word_t       merge_word;
  tag_t        rd_tag;
  word_t       rd_word;
  logic        rd_en;
  logic        wr_en;
  bmask_t      wr_mask;
  index_t      wr_index;
  tag_t        wr_tag;
  word_t       wr_word;
  ctrl_state_e state;

  dcache_mem_if mem_bus ();

  assign mem_addr_o    = mem_bus.addr;
  assign mem_valid_o   = mem_bus.valid;
  assign mem_wdata_o   = mem_bus.wdata;
  assign mem_we_o      = mem_bus.we;
  assign mem_bus.rdata = mem_rdata_i;
  assign mem_bus.ready = mem_ready_i;

  dcache_req_decode decode (
    .sel_i       (sel_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wmask_i     (wmask_i),
    .wdata_i     (wdata_i),
    .mem_rdata_i (mem_rdata_i),
    .kind_o      (kind),
    .index_o     (index),
    .tag_o       (tag),
    .merge_o     (merge_word)
  );

  dcache_ctrl #(
    .MEM_BASE (MEM_BASE)
  ) ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .kind_i     (kind),
    .index_i    (index),
    .tag_i      (tag),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .merge_i    (merge_word),
    .rd_tag_i   (rd_tag),
    .rd_word_i  (rd_word),
    .rd_en_o    (rd_en),
    .wr_en_o    (wr_en),
    .wr_mask_o  (wr_mask),
    .wr_index_o (wr_index),
    .wr_tag_o   (wr_tag),
    .wr_word_o  (wr_word),
    .state_o    (state),
    .stall_o    (stall_o),
    .mem        (mem_bus.ctrl)
  );

  // Tag array always writes the whole tag
  dcache_store #(
    .payload_t (tag_t)
  ) tag_store (
    .clk_i      (clk_i),
    .wr_en_i    (wr_en),
    .wr_mask_i  ('1),
    .wr_index_i (wr_index),
    .wr_data_i  (wr_tag),
    .rd_en_i    (rd_en),
    .rd_index_i (index),
    .rd_data_o  (rd_tag)
  );

  dcache_store #(
    .payload_t (word_t)
  ) data_store (
    .clk_i      (clk_i),
    .wr_en_i    (wr_en),
    .wr_mask_i  (wr_mask),
    .wr_index_i (wr_index),
    .wr_data_i  (wr_word),
    .rd_en_i    (rd_en),
    .rd_index_i (index),
    .rd_data_o  (rd_word)
  );

  dcache_load_return load_return (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .state_i   (state),
    .rd_word_i (rd_word),
    .rdata_o   (rdata_o)
  );

endmodule

// File: verilog/dcache_load_return.sv
`timescale 1ns/1ns

module dcache_load_return (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  dcache_bus_pkg::ctrl_state_e  state_i,
  input  logic [31:0]                  rd_word_i,
  output logic [31:0]                  rdata_o
);
  import dcache_bus_pkg::*;

  // Store output is fresh only during LOOKUP
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (state_i == LOOKUP) begin
      rdata_o <= rd_word_i;
    end
  end

endmodule

// File: verilog/dcache_store.sv
`timescale 1ns/1ns

module dcache_store #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                     clk_i,
  input  logic                     wr_en_i,
  input  dcache_bus_pkg::bmask_t   wr_mask_i,
  input  dcache_geom_pkg::index_t  wr_index_i,
  input  payload_t                 wr_data_i,
  input  logic                     rd_en_i,
  input  dcache_geom_pkg::index_t  rd_index_i,
  output payload_t                 rd_data_o
);
  import dcache_geom_pkg::*;

  localparam int W = $bits(payload_t);

  logic [W-1:0] mem_q [NUM_LINES];
  logic [W-1:0] wr_bits;

  assign wr_bits = wr_data_i;

  // Byte lanes, a narrow payload only sees lane 0
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < W; b++) begin
        if (wr_mask_i[b / 8]) begin
          mem_q[wr_index_i][b] <= wr_bits[b];
        end
      end
    end
  end

  // Read data holds until the next read enable
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= payload_t'(mem_q[rd_index_i]);
    end
  end

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl #(
  parameter logic [7:0] MEM_BASE = dcache_geom_pkg::MEM_BASE_DEFAULT
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  dcache_bus_pkg::req_kind_e    kind_i,
  input  dcache_geom_pkg::index_t      index_i,
  input  dcache_geom_pkg::tag_t        tag_i,
  input  logic [31:0]                  addr_i,
  input  logic [31:0]                  wdata_i,
  input  logic [31:0]                  merge_i,
  input  dcache_geom_pkg::tag_t        rd_tag_i,
  input  logic [31:0]                  rd_word_i,
  output logic                         rd_en_o,
  output logic                         wr_en_o,
  output logic [3:0]                   wr_mask_o,
  output dcache_geom_pkg::index_t      wr_index_o,
  output dcache_geom_pkg::tag_t        wr_tag_o,
  output logic [31:0]                  wr_word_o,
  output dcache_bus_pkg::ctrl_state_e  state_o,
  output logic                         stall_o,
  dcache_mem_if.ctrl                   mem
);
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_next;

  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;
  line_state_t          line_st;
  logic                 tag_hit;

  logic [31:0] mem_addr_q;
  logic [31:0] mem_wdata_q;
  logic [3:0]  mem_we_q;
  logic [31:0] wb_addr;
  logic [31:0] fill_addr;
  logic        start_wb;
  logic        start_rd;

  assign line_st = {valid_q[index_i], dirty_q[index_i]};
  assign tag_hit = (rd_tag_i == tag_i);

  always_comb begin
    state_next = state_q;
    case (state_q)
      IDLE: begin
        case (kind_i)
          LOAD:       state_next = line_st.valid ? LOOKUP : MEM_READ;
          STORE_FULL: state_next = line_st.dirty ? LOOKUP : FILL_WRITE;
          STORE_PART: state_next = line_st.dirty ? LOOKUP : MEM_READ;
          default:    state_next = IDLE;
        endcase
      end
      LOOKUP: begin
        // Partial store on a dirty line flushes it and refetches to merge
        if (tag_hit && kind_i == LOAD) begin
          state_next = DONE;
        end else if (tag_hit && kind_i == STORE_FULL) begin
          state_next = FILL_WRITE;
        end else if (line_st.dirty) begin
          state_next = MEM_WRITE;
        end else begin
          state_next = MEM_READ;
        end
      end
      MEM_WRITE: begin
        if (mem.ready) begin
          state_next = (kind_i == STORE_FULL) ? FILL_WRITE : MEM_READ;
        end
      end
      MEM_READ: begin
        if (mem.ready) begin
          state_next = FILL_WRITE;
        end
      end
      // Loads read the installed line back through LOOKUP
      FILL_WRITE: state_next = (kind_i == LOAD) ? LOOKUP : DONE;
      DONE:       state_next = IDLE;
      default:    state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  assign state_o = state_q;
  assign stall_o = (state_next != IDLE);

  // Array write lands on the edge into FILL_WRITE
  assign rd_en_o    = (state_next == LOOKUP);
  assign wr_en_o    = (state_next == FILL_WRITE);
  assign wr_mask_o  = {4{wr_en_o}};
  assign wr_index_o = index_i;
  assign wr_tag_o   = tag_i;

  always_comb begin
    case (kind_i)
      LOAD:       wr_word_o = mem.rdata;
      STORE_PART: wr_word_o = merge_i;
      default:    wr_word_o = wdata_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en_o) begin
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= (kind_i != LOAD);
    end
  end

  always_comb begin
    wb_addr                    = '0;
    wb_addr[31:24]             = MEM_BASE;
    wb_addr[TAG_LO +: TAG_W]   = rd_tag_i;
    wb_addr[IDX_LO +: IDX_W]   = index_i;
    fill_addr                  = addr_i;
    fill_addr[IDX_LO-1:0]      = '0;
  end

  assign start_wb = (state_next == MEM_WRITE) && (state_q != MEM_WRITE);
  assign start_rd = (state_next == MEM_READ) && (state_q != MEM_READ);

  // Victim tag and word are valid in LOOKUP, the only way into MEM_WRITE
  always_ff @(posedge clk_i) begin
    if (start_wb) begin
      mem_addr_q  <= wb_addr;
      mem_wdata_q <= rd_word_i;
    end else if (start_rd) begin
      mem_addr_q  <= fill_addr;
      mem_wdata_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_we_q <= '0;
    end else if (start_wb) begin
      mem_we_q <= 4'b1111;
    end else if (state_next != MEM_WRITE) begin
      mem_we_q <= '0;
    end
  end

  assign mem.addr  = mem_addr_q;
  assign mem.wdata = mem_wdata_q;
  assign mem.we    = mem_we_q;
  assign mem.valid = (state_q == MEM_READ) || (state_q == MEM_WRITE);

  a_mem_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr) && $stable(mem.we)
  ) else $error("memory request dropped or changed before ready");

  a_port_excl: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(wr_en_o && rd_en_o)
  ) else $error("store read and write enabled together");

endmodule

// File: verilog/dcache_req_decode.sv
`timescale 1ns/1ns

module dcache_req_decode (
  input  logic                       sel_i,
  input  logic                       we_i,
  input  logic [31:0]                addr_i,
  input  dcache_bus_pkg::bmask_t     wmask_i,
  input  logic [31:0]                wdata_i,
  input  logic [31:0]                mem_rdata_i,
  output dcache_bus_pkg::req_kind_e  kind_o,
  output dcache_geom_pkg::index_t    index_o,
  output dcache_geom_pkg::tag_t      tag_o,
  output logic [31:0]                merge_o
);
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  logic mask_legal;

  assign index_o = addr_i[IDX_LO +: IDX_W];
  assign tag_o   = addr_i[TAG_LO +: TAG_W];

  always_comb begin
    if (!sel_i) begin
      kind_o = NONE;
    end else if (!we_i) begin
      kind_o = LOAD;
    end else if (wmask_i == 4'b1111) begin
      kind_o = STORE_FULL;
    end else begin
      kind_o = STORE_PART;
    end
  end

  // Store data comes in the low bytes, the mask picks the target lanes
  always_comb begin
    merge_o    = mem_rdata_i;
    mask_legal = 1'b1;
    case (wmask_i)
      4'b0001: merge_o[7:0]   = wdata_i[7:0];
      4'b0010: merge_o[15:8]  = wdata_i[7:0];
      4'b0100: merge_o[23:16] = wdata_i[7:0];
      4'b1000: merge_o[31:24] = wdata_i[7:0];
      4'b0011: merge_o[15:0]  = wdata_i[15:0];
      4'b1100: merge_o[31:16] = wdata_i[15:0];
      4'b1111: merge_o        = wdata_i;
      default: mask_legal     = 1'b0;
    endcase

    if (sel_i && we_i) begin
      a_store_mask_legal: assert #0 (mask_legal)
        else $error("illegal store mask %b", wmask_i);
    end
  end

endmodule

// File: verilog/dcache_mem_if.sv
`timescale 1ns/1ns

interface dcache_mem_if;

  // Request side, held stable while valid is high and ready is low
  logic [31:0] addr;
  logic        valid;
  logic [31:0] wdata;
  logic [3:0]  we;

  // Response side, rdata qualified by ready
  logic [31:0] rdata;
  logic        ready;

  modport ctrl (
    output addr,
    output valid,
    output wdata,
    output we,
    input  rdata,
    input  ready
  );

  modport port (
    input  addr,
    input  valid,
    input  wdata,
    input  we,
    output rdata,
    output ready
  );

endinterface

// File: verilog/dcache_bus_pkg.sv
package dcache_bus_pkg;

  // Core request as seen by the controller
  typedef enum logic [1:0] {
    NONE       = 2'd0,
    LOAD       = 2'd1,
    STORE_FULL = 2'd2,
    STORE_PART = 2'd3
  } req_kind_e;

  // One bit per byte lane, lane 0 is bits 7:0
  typedef logic [3:0] bmask_t;

  // Miss handling states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOOKUP     = 3'd1,
    FILL_WRITE = 3'd2,
    MEM_READ   = 3'd3,
    MEM_WRITE  = 3'd4,
    DONE       = 3'd5
  } ctrl_state_e;

endpackage

// File: verilog/dcache_geom_pkg.sv
package dcache_geom_pkg;

  // Direct mapped, one 32-bit word per line
  localparam int NUM_LINES = 512;
  localparam int IDX_W     = 9;
  localparam int TAG_W     = 8;

  // Address field positions
  localparam int IDX_LO = 2;
  localparam int TAG_LO = 11;

  // Upper address byte of write-back traffic
  localparam logic [7:0] MEM_BASE_DEFAULT = 8'h40;

  typedef logic [IDX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [31:0]      word_t;

  // Per-line bookkeeping
  typedef struct packed {
    logic valid;
    logic dirty;
  } line_state_t;

endpackage
